// File: common/riscv_isa_pkg.sv
/*
  RISC-V operation encodings for the integer execution cluster
  cluster opcodes, ALU functions and the MDU control word
*/

package riscv_isa_pkg;

  ////////////////////
  // cluster opcodes
  ////////////////////

  // ALU group in the lower half, M extension in the upper half
  typedef enum logic [3:0] {
    OP_ADD    = 4'd0,
    OP_SUB    = 4'd1,
    OP_AND    = 4'd2,
    OP_OR     = 4'd3,
    OP_XOR    = 4'd4,
    OP_SLT    = 4'd5,
    OP_SLTU   = 4'd6,
    // rd = imm
    OP_LI     = 4'd7,
    OP_MUL    = 4'd8,
    OP_MULH   = 4'd9,
    OP_MULHSU = 4'd10,
    OP_MULHU  = 4'd11,
    OP_DIV    = 4'd12,
    OP_DIVU   = 4'd13,
    OP_REM    = 4'd14,
    OP_REMU   = 4'd15
  } exec_op_t;

  ////////////////////
  // ALU functions
  ////////////////////

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLT  = 3'd5,
    ALU_SLTU = 3'd6,
    // pass operand b, used by load-immediate
    ALU_PASS = 3'd7
  } alu_op_t;

  ////////////////////
  // MDU control
  ////////////////////

  // result select
  typedef enum logic [1:0] {
    M_MUL = 2'b00,  // low half of product
    M_MUH = 2'b01,  // high half of product
    M_DIV = 2'b10,
    M_REM = 2'b11
  } mdu_op_t;

  // s12 operand signedness
  // 00 unsigned*unsigned, 10 signed*unsigned, 11 signed*signed
  typedef struct packed {
    mdu_op_t    op;
    logic [1:0] s12;
  } ctl_m_t;

endpackage: riscv_isa_pkg

// File: common/exec_cfg_pkg.sv
/*
  execution cluster configuration
  data width, register file size and unit latencies
*/

package exec_cfg_pkg;

  // data path width
  localparam int XW = 32;

  // register file
  localparam int NREG = 32;
  localparam int RW   = 5;

  ////////////////////
  // unit latencies
  ////////////////////

  // issue to write request, in cycles
  localparam int ALU_LAT = 1;
  // operand register plus result register
  localparam int MDU_LAT = 2;

endpackage: exec_cfg_pkg

// File: mdu/r5p_mdu.sv
/*
  multiply/divide unit for the M extension
  registered operands, combinational core, registered result held until grant
*/

`timescale 1ns/1ns

module r5p_mdu #(
  int unsigned XW = 32
)(
  input  logic                        clk,
  input  logic                        rst,
  // dispatch
  input  logic                        go,
  input  riscv_isa_pkg::ctl_m_t       ctl,
  input  logic [XW-1:0]               rs1,
  input  logic [XW-1:0]               rs2,
  input  logic [exec_cfg_pkg::RW-1:0] rd_idx,
  // write port
  input  logic                        gnt,
  output logic                        req,
  output logic [exec_cfg_pkg::RW-1:0] rd_out_idx,
  output logic [XW-1:0]               rd
);

  import riscv_isa_pkg::*;

  // operand stage
  logic                        v_q;
  ctl_m_t                      ctl_q;
  logic [XW-1:0]               a_q;
  logic [XW-1:0]               b_q;
  logic [exec_cfg_pkg::RW-1:0] idx_q;

  // core
  logic [2*XW-1:0]      a_ext;
  logic [2*XW-1:0]      b_ext;
  logic [2*XW-1:0]      mul;
  logic [XW-1:0]        divu;
  logic [XW-1:0]        remu;
  logic signed [XW-1:0] divs;
  logic signed [XW-1:0] rems;
  logic [XW-1:0]        div;
  logic [XW-1:0]        rem;
  logic [XW-1:0]        res;
  logic                 by_zero;
  logic                 ovf;

  ////////////////////
  // operand register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      v_q <= 1'b0;
    else
      v_q <= go;
  end

  always_ff @(posedge clk)
  begin
    if (go)
    begin
      ctl_q <= ctl;
      a_q   <= rs1;
      b_q   <= rs2;
      idx_q <= rd_idx;
    end
  end

  ////////////////////
  // multiply
  ////////////////////

  // extend to product width per s12, low 2*XW bits of product are exact
  assign a_ext = {{XW{ctl_q.s12[1] & a_q[XW-1]}}, a_q};
  assign b_ext = {{XW{ctl_q.s12[0] & b_q[XW-1]}}, b_q};
  assign mul   = a_ext * b_ext;

  ////////////////////
  // divide
  ////////////////////

  assign by_zero = ~|b_q;
  // most negative by -1
  assign ovf     = a_q[XW-1] & ~|a_q[XW-2:0] & &b_q;

  always_comb
  begin
    divu = a_q / b_q;
    remu = a_q % b_q;
    divs = $signed(a_q) / $signed(b_q);
    rems = $signed(a_q) % $signed(b_q);
    // x/0 gives all ones, x%0 gives x
    if (by_zero)
    begin
      div = '1;
      rem = a_q;
    end
    // signed path, overflow clamps quotient and zeroes remainder
    else if (ctl_q.s12[0])
    begin
      div = ovf ? {1'b1, {(XW-1){1'b0}}} : divs;
      rem = ovf ? '0 : rems;
    end
    else
    begin
      div = divu;
      rem = remu;
    end
  end

  // result select
  always_comb
  begin
    case (ctl_q.op)
      M_MUL:   res = mul[XW-1:0];
      M_MUH:   res = mul[2*XW-1:XW];
      M_DIV:   res = div;
      default: res = rem;
    endcase
  end

  ////////////////////
  // result register
  ////////////////////

  // request stays up until granted, a new result re-arms it
  always_ff @(posedge clk)
  begin
    if (rst)
      req <= 1'b0;
    else if (v_q)
      req <= 1'b1;
    else if (gnt)
      req <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (v_q)
    begin
      rd         <= res;
      rd_out_idx <= idx_q;
    end
  end

endmodule: r5p_mdu

// File: hdl/r5p_alu.sv
/*
  integer ALU with registered result
  an ungranted result is held and flagged back to issue
*/

`timescale 1ns/1ns

module r5p_alu (
  input  logic                        clk,
  input  logic                        rst,
  // dispatch
  input  logic                        go,
  input  riscv_isa_pkg::alu_op_t      op,
  input  logic [exec_cfg_pkg::XW-1:0] a,
  input  logic [exec_cfg_pkg::XW-1:0] b,
  input  logic [exec_cfg_pkg::RW-1:0] rd_idx,
  // write port
  input  logic                        gnt,
  output logic                        req,
  output logic [exec_cfg_pkg::RW-1:0] rd_out_idx,
  output logic [exec_cfg_pkg::XW-1:0] result,
  output logic                        hold
);

  import riscv_isa_pkg::*;
  import exec_cfg_pkg::*;

  logic [XW-1:0] y;

  // function
  always_comb
  begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_SLT:  y = {{(XW-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: y = {{(XW-1){1'b0}}, a < b};
      default:  y = b;
    endcase
  end

  // lost arbitration this cycle
  assign hold = req & ~gnt;

  ////////////////////
  // result register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      req <= 1'b0;
    else if (!hold)
      req <= go;
  end

  // payload frozen while held
  always_ff @(posedge clk)
  begin
    if (go && !hold)
    begin
      result     <= y;
      rd_out_idx <= rd_idx;
    end
  end

endmodule: r5p_alu

// File: hdl/r5p_regfile.sv
/*
  integer register file, x0 reads zero
  two operand read ports, one write port, one debug read port
*/

`timescale 1ns/1ns

module r5p_regfile (
  input  logic                        clk,
  input  logic                        rst,
  // operand reads
  input  logic [exec_cfg_pkg::RW-1:0] ra1,
  input  logic [exec_cfg_pkg::RW-1:0] ra2,
  output logic [exec_cfg_pkg::XW-1:0] rd1,
  output logic [exec_cfg_pkg::XW-1:0] rd2,
  // writeback
  input  logic                        we,
  input  logic [exec_cfg_pkg::RW-1:0] wa,
  input  logic [exec_cfg_pkg::XW-1:0] wd,
  // debug
  input  logic [exec_cfg_pkg::RW-1:0] dbg_addr,
  output logic [exec_cfg_pkg::XW-1:0] dbg_data
);

  import exec_cfg_pkg::*;

  logic [XW-1:0] regs [NREG];

  // write, x0 never written so it stays zero
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NREG; i++)
        regs[i] <= '0;
    end
    else if (we && (wa != '0))
      regs[wa] <= wd;
  end

  ////////////////////
  // read ports
  ////////////////////

  // no write bypass, a write shows up next cycle
  assign rd1      = regs[ra1];
  assign rd2      = regs[ra2];
  assign dbg_data = regs[dbg_addr];

endmodule: r5p_regfile

// File: hdl/r5p_issue.sv
/*
  issue stage, operand read and scoreboard hazard check
  decodes the opcode and dispatches to the ALU or the MDU
*/

`timescale 1ns/1ns

module r5p_issue (
  input  logic                        clk,
  input  logic                        rst,
  // issue
  input  logic                        issue_valid,
  input  riscv_isa_pkg::exec_op_t     issue_op,
  input  logic [exec_cfg_pkg::RW-1:0] issue_rd,
  input  logic [exec_cfg_pkg::RW-1:0] issue_rs1,
  input  logic [exec_cfg_pkg::RW-1:0] issue_rs2,
  input  logic [exec_cfg_pkg::XW-1:0] issue_imm,
  output logic                        issue_ready,
  // register file
  output logic [exec_cfg_pkg::RW-1:0] ra1,
  output logic [exec_cfg_pkg::RW-1:0] ra2,
  input  logic [exec_cfg_pkg::XW-1:0] rd1,
  input  logic [exec_cfg_pkg::XW-1:0] rd2,
  // ALU dispatch
  input  logic                        alu_hold,
  output logic                        alu_go,
  output riscv_isa_pkg::alu_op_t      alu_op,
  output logic [exec_cfg_pkg::XW-1:0] alu_a,
  output logic [exec_cfg_pkg::XW-1:0] alu_b,
  output logic [exec_cfg_pkg::RW-1:0] alu_rd,
  // MDU dispatch
  output logic                        mdu_go,
  output riscv_isa_pkg::ctl_m_t       mdu_ctl,
  output logic [exec_cfg_pkg::XW-1:0] mdu_a,
  output logic [exec_cfg_pkg::XW-1:0] mdu_b,
  output logic [exec_cfg_pkg::RW-1:0] mdu_rd,
  // writeback, clears busy
  input  logic                        wb_valid,
  input  logic [exec_cfg_pkg::RW-1:0] wb_rd
);

  import riscv_isa_pkg::*;
  import exec_cfg_pkg::*;

  logic [NREG-1:0] busy;
  logic            hazard;
  logic            fire;
  logic            is_mdu;
  alu_op_t         alu_fn;
  ctl_m_t          m_ctl;

  ////////////////////
  // decode
  ////////////////////

  always_comb
  begin
    is_mdu = 1'b1;
    alu_fn = ALU_ADD;
    m_ctl  = '{op: M_MUL, s12: 2'b11};
    case (issue_op)
      OP_ADD:    is_mdu = 1'b0;
      OP_SUB:    begin is_mdu = 1'b0; alu_fn = ALU_SUB;  end
      OP_AND:    begin is_mdu = 1'b0; alu_fn = ALU_AND;  end
      OP_OR:     begin is_mdu = 1'b0; alu_fn = ALU_OR;   end
      OP_XOR:    begin is_mdu = 1'b0; alu_fn = ALU_XOR;  end
      OP_SLT:    begin is_mdu = 1'b0; alu_fn = ALU_SLT;  end
      OP_SLTU:   begin is_mdu = 1'b0; alu_fn = ALU_SLTU; end
      OP_LI:     begin is_mdu = 1'b0; alu_fn = ALU_PASS; end
      // low half same for any signedness
      OP_MUL:    m_ctl = '{op: M_MUL, s12: 2'b11};
      OP_MULH:   m_ctl = '{op: M_MUH, s12: 2'b11};
      OP_MULHSU: m_ctl = '{op: M_MUH, s12: 2'b10};
      OP_MULHU:  m_ctl = '{op: M_MUH, s12: 2'b00};
      OP_DIV:    m_ctl = '{op: M_DIV, s12: 2'b11};
      OP_DIVU:   m_ctl = '{op: M_DIV, s12: 2'b00};
      OP_REM:    m_ctl = '{op: M_REM, s12: 2'b11};
      default:   m_ctl = '{op: M_REM, s12: 2'b00};
    endcase
  end

  ////////////////////
  // scoreboard
  ////////////////////

  // sources and destination must all be idle
  assign hazard      = busy[issue_rs1] | busy[issue_rs2] | busy[issue_rd];
  assign issue_ready = ~hazard & ~alu_hold;
  assign fire        = issue_valid & issue_ready;

  // clear on writeback, set on dispatch, x0 never marked
  always_ff @(posedge clk)
  begin
    if (rst)
      busy <= '0;
    else
    begin
      if (wb_valid)
        busy[wb_rd] <= 1'b0;
      if (fire && (issue_rd != '0))
        busy[issue_rd] <= 1'b1;
    end
  end

  ////////////////////
  // dispatch
  ////////////////////

  assign ra1 = issue_rs1;
  assign ra2 = issue_rs2;

  assign alu_go = fire & ~is_mdu;
  assign alu_op = alu_fn;
  assign alu_a  = rd1;
  // load-immediate takes imm as b
  assign alu_b  = (issue_op == OP_LI) ? issue_imm : rd2;
  assign alu_rd = issue_rd;

  assign mdu_go  = fire & is_mdu;
  assign mdu_ctl = m_ctl;
  assign mdu_a   = rd1;
  assign mdu_b   = rd2;
  assign mdu_rd  = issue_rd;

endmodule: r5p_issue

// File: hdl/r5p_wb_arbiter.sv
/*
  fixed-priority arbiter for the shared register file write port
  the MDU always wins as it holds the older operation
*/

`timescale 1ns/1ns

module r5p_wb_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  // ALU request
  input  logic                        alu_req,
  input  logic [exec_cfg_pkg::RW-1:0] alu_rd,
  input  logic [exec_cfg_pkg::XW-1:0] alu_data,
  // MDU request
  input  logic                        mdu_req,
  input  logic [exec_cfg_pkg::RW-1:0] mdu_rd,
  input  logic [exec_cfg_pkg::XW-1:0] mdu_data,
  // grants
  output logic                        alu_gnt,
  output logic                        mdu_gnt,
  // write port
  output logic                        wb_valid,
  output logic [exec_cfg_pkg::RW-1:0] wb_rd,
  output logic [exec_cfg_pkg::XW-1:0] wb_data
);

  ////////////////////
  // priority
  ////////////////////

  // MDU is never refused
  assign mdu_gnt = mdu_req;
  // a losing ALU keeps its request for the next cycle
  assign alu_gnt = alu_req & ~mdu_req;

  ////////////////////
  // write port mux
  ////////////////////

  assign wb_valid = alu_req | mdu_req;
  assign wb_rd    = mdu_gnt ? mdu_rd : alu_rd;
  assign wb_data  = mdu_gnt ? mdu_data : alu_data;

endmodule: r5p_wb_arbiter

// File: hdl/r5p_exec.sv
/*
  integer execution cluster top
  issue, register file, ALU, MDU and write port arbiter
*/

`timescale 1ns/1ns

module r5p_exec (
  input  logic                        clk,
  input  logic                        rst,
  // issue
  input  logic                        issue_valid,
  input  riscv_isa_pkg::exec_op_t     issue_op,
  input  logic [exec_cfg_pkg::RW-1:0] issue_rd,
  input  logic [exec_cfg_pkg::RW-1:0] issue_rs1,
  input  logic [exec_cfg_pkg::RW-1:0] issue_rs2,
  input  logic [exec_cfg_pkg::XW-1:0] issue_imm,
  output logic                        issue_ready,
  // writeback observation
  output logic                        wb_valid,
  output logic [exec_cfg_pkg::RW-1:0] wb_rd,
  output logic [exec_cfg_pkg::XW-1:0] wb_data,
  // debug read
  input  logic [exec_cfg_pkg::RW-1:0] dbg_addr,
  output logic [exec_cfg_pkg::XW-1:0] dbg_data
);

  import riscv_isa_pkg::*;
  import exec_cfg_pkg::*;

  // register file reads
  logic [RW-1:0] ra1;
  logic [RW-1:0] ra2;
  logic [XW-1:0] rd1;
  logic [XW-1:0] rd2;

  // ALU side
  logic          alu_go;
  alu_op_t       alu_op;
  logic [XW-1:0] alu_a;
  logic [XW-1:0] alu_b;
  logic [RW-1:0] alu_rd;
  logic          alu_req;
  logic          alu_gnt;
  logic          alu_hold;
  logic [RW-1:0] alu_wb_rd;
  logic [XW-1:0] alu_wb_data;

  // MDU side
  logic          mdu_go;
  ctl_m_t        mdu_ctl;
  logic [XW-1:0] mdu_a;
  logic [XW-1:0] mdu_b;
  logic [RW-1:0] mdu_rd;
  logic          mdu_req;
  logic          mdu_gnt;
  logic [RW-1:0] mdu_wb_rd;
  logic [XW-1:0] mdu_wb_data;

  ////////////////////
  // issue and operands
  ////////////////////

  r5p_issue u_issue (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_rd    (issue_rd),
    .issue_rs1   (issue_rs1),
    .issue_rs2   (issue_rs2),
    .issue_imm   (issue_imm),
    .issue_ready (issue_ready),
    .ra1         (ra1),
    .ra2         (ra2),
    .rd1         (rd1),
    .rd2         (rd2),
    .alu_hold    (alu_hold),
    .alu_go      (alu_go),
    .alu_op      (alu_op),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_rd      (alu_rd),
    .mdu_go      (mdu_go),
    .mdu_ctl     (mdu_ctl),
    .mdu_a       (mdu_a),
    .mdu_b       (mdu_b),
    .mdu_rd      (mdu_rd),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd)
  );

  // write port fed straight from the arbiter
  r5p_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .ra1      (ra1),
    .ra2      (ra2),
    .rd1      (rd1),
    .rd2      (rd2),
    .we       (wb_valid),
    .wa       (wb_rd),
    .wd       (wb_data),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  ////////////////////
  // execution units
  ////////////////////

  r5p_alu u_alu (
    .clk        (clk),
    .rst        (rst),
    .go         (alu_go),
    .op         (alu_op),
    .a          (alu_a),
    .b          (alu_b),
    .rd_idx     (alu_rd),
    .gnt        (alu_gnt),
    .req        (alu_req),
    .rd_out_idx (alu_wb_rd),
    .result     (alu_wb_data),
    .hold       (alu_hold)
  );

  r5p_mdu #(
    .XW (XW)
  ) u_mdu (
    .clk        (clk),
    .rst        (rst),
    .go         (mdu_go),
    .ctl        (mdu_ctl),
    .rs1        (mdu_a),
    .rs2        (mdu_b),
    .rd_idx     (mdu_rd),
    .gnt        (mdu_gnt),
    .req        (mdu_req),
    .rd_out_idx (mdu_wb_rd),
    .rd         (mdu_wb_data)
  );

  ////////////////////
  // writeback
  ////////////////////

  r5p_wb_arbiter u_wb_arbiter (
    .clk      (clk),
    .rst      (rst),
    .alu_req  (alu_req),
    .alu_rd   (alu_wb_rd),
    .alu_data (alu_wb_data),
    .mdu_req  (mdu_req),
    .mdu_rd   (mdu_wb_rd),
    .mdu_data (mdu_wb_data),
    .alu_gnt  (alu_gnt),
    .mdu_gnt  (mdu_gnt),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule: r5p_exec

// File: verification/r5p_exec_tb.sv
/*
  testbench for the integer execution cluster
  table-driven issue, reference model, writeback and debug readback checks
*/

`timescale 1ns/1ns

module r5p_exec_tb;

  import riscv_isa_pkg::*;

  localparam int MAXE = 64;

  // DUT ports
  logic        clk;
  logic        rst;
  logic        issue_valid;
  exec_op_t    issue_op;
  logic [4:0]  issue_rd;
  logic [4:0]  issue_rs1;
  logic [4:0]  issue_rs2;
  logic [31:0] issue_imm;
  logic        issue_ready;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;

  ////////////////////
  // stimulus table
  ////////////////////

  exec_op_t    t_op    [MAXE];
  logic [4:0]  t_rd    [MAXE];
  logic [4:0]  t_rs1   [MAXE];
  logic [4:0]  t_rs2   [MAXE];
  logic [31:0] t_imm   [MAXE];
  // use t_exp instead of the model
  logic        t_fix   [MAXE];
  logic [31:0] t_exp   [MAXE];
  // drain everything before issue
  logic        t_iso   [MAXE];
  // expected issue to wb cycles or 0 when unchecked
  int          t_lat   [MAXE];
  // expected not-ready cycles before issue or -1 when unchecked
  int          t_stall [MAXE];
  int          t_grp   [MAXE];
  int          n_ent;

  // architectural state in program order
  logic [31:0] shadow [32];

  // outstanding writebacks in issue order
  logic [4:0]  q_rd   [$];
  logic [31:0] q_data [$];
  int          q_lat  [$];
  int          q_cyc  [$];

  int cyc;
  int limit;
  int seed;
  int n_checks;
  int n_errors;

  r5p_exec UUT (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_rd    (issue_rd),
    .issue_rs1   (issue_rs1),
    .issue_rs2   (issue_rs2),
    .issue_imm   (issue_imm),
    .issue_ready (issue_ready),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .dbg_addr    (dbg_addr),
    .dbg_data    (dbg_data)
  );

  // 20 ns period
  initial
    clk = 1'b0;
  always #10 clk = ~clk;

  // cycle count and run limit
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (limit > 0 && cyc >= limit)
    begin
      $display("timeout: the table did not finish within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    begin
      n_checks++;
      if (got !== exp)
      begin
        n_errors++;
        $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] ref_result(input exec_op_t op, input logic [31:0] a,
                                             input logic [31:0] b, input logic [31:0] imm);
    logic [63:0] p_ss;
    logic [63:0] p_su;
    logic [63:0] p_uu;
    int          ia;
    int          ib;
    logic        ovf;
    logic [31:0] qs;
    logic [31:0] rs;
    logic [31:0] qu;
    logic [31:0] ru;
    logic [31:0] r;
    begin
      // 64-bit products with each operand sign or zero extended
      p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      p_su = {{32{a[31]}}, a} * {32'b0, b};
      p_uu = {32'b0, a} * {32'b0, b};
      ia   = a;
      ib   = b;
      ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
      qs   = '0;
      rs   = '0;
      qu   = '0;
      ru   = '0;
      if (b != 0)
      begin
        qu = a / b;
        ru = a % b;
        if (!ovf)
        begin
          qs = ia / ib;
          rs = ia % ib;
        end
      end
      case (op)
        OP_ADD:    r = a + b;
        OP_SUB:    r = a - b;
        OP_AND:    r = a & b;
        OP_OR:     r = a | b;
        OP_XOR:    r = a ^ b;
        OP_SLT:    r = {31'b0, ia < ib};
        OP_SLTU:   r = {31'b0, a < b};
        OP_LI:     r = imm;
        OP_MUL:    r = p_ss[31:0];
        OP_MULH:   r = p_ss[63:32];
        OP_MULHSU: r = p_su[63:32];
        OP_MULHU:  r = p_uu[63:32];
        // zero divisor and signed overflow rules
        OP_DIV:    r = (b == 0) ? 32'hffff_ffff : (ovf ? 32'h8000_0000 : qs);
        OP_DIVU:   r = (b == 0) ? 32'hffff_ffff : qu;
        OP_REM:    r = (b == 0) ? a : (ovf ? 32'h0 : rs);
        default:   r = (b == 0) ? a : ru;
      endcase
      return r;
    end
  endfunction

  ////////////////////
  // table building
  ////////////////////

  task automatic push_entry(input int g, input exec_op_t op, input int rd, input int rs1,
                            input int rs2, input logic [31:0] imm, input logic fix,
                            input logic [31:0] exp);
    begin
      t_grp[n_ent]   = g;
      t_op[n_ent]    = op;
      t_rd[n_ent]    = 5'(rd);
      t_rs1[n_ent]   = 5'(rs1);
      t_rs2[n_ent]   = 5'(rs2);
      t_imm[n_ent]   = imm;
      t_fix[n_ent]   = fix;
      t_exp[n_ent]   = exp;
      t_iso[n_ent]   = 1'b0;
      t_lat[n_ent]   = 0;
      t_stall[n_ent] = -1;
      n_ent++;
    end
  endtask

  task automatic load_imm(input int g, input int rd, input logic [31:0] imm);
    push_entry(g, OP_LI, rd, 0, 0, imm, 1'b0, '0);
  endtask

  task automatic add_op(input int g, input exec_op_t op, input int rd, input int rs1,
                        input int rs2);
    push_entry(g, op, rd, rs1, rs2, '0, 1'b0, '0);
  endtask

  task automatic add_fixed(input int g, input exec_op_t op, input int rd, input int rs1,
                           input int rs2, input logic [31:0] exp);
    push_entry(g, op, rd, rs1, rs2, '0, 1'b1, exp);
  endtask

  // timing expectations on the latest entry
  task automatic set_timing(input logic iso, input int lat, input int stall);
    begin
      t_iso[n_ent-1]   = iso;
      t_lat[n_ent-1]   = lat;
      t_stall[n_ent-1] = stall;
    end
  endtask

  task automatic build_table;
    begin
      n_ent = 0;
      // ALU group with x3 = -7 for the negative slt
      load_imm(1, 1, $random(seed));
      load_imm(1, 2, $random(seed));
      load_imm(1, 3, 32'hffff_fff9);
      load_imm(1, 4, 32'd5);
      add_op(1, OP_ADD, 5, 1, 2);
      add_op(1, OP_SUB, 6, 1, 2);
      add_op(1, OP_AND, 7, 1, 2);
      add_op(1, OP_OR, 8, 1, 2);
      add_op(1, OP_XOR, 9, 1, 2);
      add_fixed(1, OP_SLT, 10, 3, 4, 32'd1);
      add_fixed(1, OP_SLTU, 11, 3, 4, 32'd0);
      add_op(1, OP_SLT, 12, 1, 2);
      add_op(1, OP_SLTU, 13, 1, 2);
      // multiply with corner operands in x14 and x15
      load_imm(2, 14, 32'h8000_0000);
      load_imm(2, 15, 32'hffff_ffff);
      load_imm(2, 16, $random(seed));
      load_imm(2, 17, $random(seed));
      add_op(2, OP_MUL, 18, 16, 17);
      add_op(2, OP_MULH, 19, 16, 17);
      add_op(2, OP_MULHSU, 20, 16, 17);
      add_op(2, OP_MULHU, 21, 16, 17);
      add_fixed(2, OP_MULH, 22, 14, 14, 32'h4000_0000);
      add_fixed(2, OP_MULHU, 23, 15, 15, 32'hffff_fffe);
      add_fixed(2, OP_MULHSU, 24, 15, 15, 32'hffff_ffff);
      add_fixed(2, OP_MUL, 25, 14, 0, 32'h0);
      add_fixed(2, OP_MULH, 26, 14, 15, 32'h0);
      // divide with zero divisor and signed overflow
      load_imm(3, 1, $random(seed));
      load_imm(3, 2, $random(seed));
      load_imm(3, 6, 32'h1234_5678);
      add_fixed(3, OP_DIV, 3, 1, 0, 32'hffff_ffff);
      add_fixed(3, OP_DIVU, 4, 1, 0, 32'hffff_ffff);
      add_fixed(3, OP_REM, 5, 6, 0, 32'h1234_5678);
      add_fixed(3, OP_REMU, 7, 6, 0, 32'h1234_5678);
      add_fixed(3, OP_DIV, 8, 14, 15, 32'h8000_0000);
      add_fixed(3, OP_REM, 9, 14, 15, 32'h0);
      add_fixed(3, OP_DIVU, 10, 14, 15, 32'h0);
      add_fixed(3, OP_REMU, 11, 14, 15, 32'h8000_0000);
      add_op(3, OP_DIV, 12, 1, 2);
      add_op(3, OP_DIVU, 13, 1, 2);
      add_op(3, OP_REM, 16, 1, 2);
      add_op(3, OP_REMU, 17, 1, 2);
      // dependent chain 7*7=49 then 56/7=8 then 8-49=-41 then 49%-41=8
      load_imm(4, 1, 32'd7);
      add_op(4, OP_MUL, 2, 1, 1);
      add_op(4, OP_ADD, 3, 2, 1);
      add_op(4, OP_DIV, 4, 3, 1);
      add_fixed(4, OP_SUB, 4, 4, 2, 32'hffff_ffd7);
      add_op(4, OP_REM, 5, 2, 4);
      add_op(4, OP_ADD, 0, 4, 2);
      add_fixed(4, OP_ADD, 6, 0, 5, 32'd8);
      // MDU then ALU one cycle apart
      load_imm(5, 20, $random(seed));
      load_imm(5, 21, $random(seed));
      add_op(5, OP_MUL, 22, 20, 21);
      set_timing(1'b1, 2, 0);
      add_op(5, OP_ADD, 23, 20, 21);
      set_timing(1'b0, 2, 0);
      add_op(5, OP_XOR, 24, 20, 21);
      set_timing(1'b0, 0, 1);
      // isolated latencies
      load_imm(6, 25, $random(seed));
      add_op(6, OP_ADD, 26, 25, 25);
      set_timing(1'b1, 1, 0);
      add_op(6, OP_MULHU, 27, 25, 25);
      set_timing(1'b1, 2, 0);
    end
  endtask

  function automatic string test_name(input int g);
    case (g)
      1:       return "alu and load-immediate";
      2:       return "multiply";
      3:       return "divide and remainder";
      4:       return "hazard chain and x0";
      5:       return "write port collision";
      default: return "writeback timing";
    endcase
  endfunction

  ////////////////////
  // writeback monitor
  ////////////////////

  // wb settles from unit registers well before the falling edge
  always @(negedge clk)
  begin
    if (!rst && wb_valid)
    begin
      if (q_rd.size() == 0)
      begin
        n_errors++;
        $display("error at %0t: writeback to x%0d with nothing outstanding", $time, wb_rd);
      end
      else
      begin
        check("wb_rd", 32'(wb_rd), 32'(q_rd[0]));
        check("wb_data", wb_data, q_data[0]);
        if (q_lat[0] != 0)
          check("wb latency", 32'(cyc - q_cyc[0]), 32'(q_lat[0]));
        void'(q_rd.pop_front());
        void'(q_data.pop_front());
        void'(q_lat.pop_front());
        void'(q_cyc.pop_front());
      end
    end
  end

  ////////////////////
  // driver
  ////////////////////

  task automatic issue_entry(input int i);
    int          stall;
    logic [31:0] val;
    begin
      stall       = 0;
      issue_op    = t_op[i];
      issue_rd    = t_rd[i];
      issue_rs1   = t_rs1[i];
      issue_rs2   = t_rs2[i];
      issue_imm   = t_imm[i];
      issue_valid = 1'b1;
      @(negedge clk);
      while (!issue_ready)
      begin
        stall++;
        @(negedge clk);
      end
      // taken at the coming edge
      val = ref_result(t_op[i], shadow[t_rs1[i]], shadow[t_rs2[i]], t_imm[i]);
      if (t_fix[i])
        val = t_exp[i];
      if (t_rd[i] != 5'd0)
        shadow[t_rd[i]] = val;
      q_rd.push_back(t_rd[i]);
      q_data.push_back(val);
      q_lat.push_back(t_lat[i]);
      q_cyc.push_back(cyc);
      if (t_stall[i] >= 0)
        check("issue_ready stall cycles", 32'(stall), 32'(t_stall[i]));
      @(posedge clk);
      #1;
      issue_valid = 1'b0;
    end
  endtask

  // wait out all results plus the edge that writes the last one
  task automatic drain;
    begin
      issue_valid = 1'b0;
      while (q_rd.size() != 0)
        @(negedge clk);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic read_back(input int g);
    int i;
    begin
      for (i = 0; i < n_ent; i++)
      begin
        if (t_grp[i] == g)
        begin
          dbg_addr = t_rd[i];
          @(negedge clk);
          check($sformatf("dbg_data x%0d", t_rd[i]), dbg_data, shadow[t_rd[i]]);
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  initial
  begin
    int i;
    int e0;
    int c0;
    cyc         = 0;
    limit       = 0;
    n_checks    = 0;
    n_errors    = 0;
    seed        = 32'hdc4b_140e;
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_op    = OP_ADD;
    issue_rd    = '0;
    issue_rs1   = '0;
    issue_rs2   = '0;
    issue_imm   = '0;
    dbg_addr    = '0;
    for (i = 0; i < 32; i++)
      shadow[i] = '0;
    build_table();
    limit = 4 * n_ent + 100;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    e0  = 0;
    c0  = 0;
    for (i = 0; i < n_ent; i++)
    begin
      if (t_iso[i])
        drain();
      issue_entry(i);
      // at a group end settle and read destinations back
      if (i == n_ent - 1 || t_grp[i+1] != t_grp[i])
      begin
        drain();
        read_back(t_grp[i]);
        $display("test %0d %s: %0d checks, %0d errors", t_grp[i], test_name(t_grp[i]),
                 n_checks - c0, n_errors - e0);
        e0 = n_errors;
        c0 = n_checks;
      end
    end
    $display("done: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule: r5p_exec_tb

// File: r5p_exec.f
common/riscv_isa_pkg.sv
common/exec_cfg_pkg.sv
mdu/r5p_mdu.sv
hdl/r5p_alu.sv
hdl/r5p_regfile.sv
hdl/r5p_issue.sv
hdl/r5p_wb_arbiter.sv
hdl/r5p_exec.sv
verification/r5p_exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the r5p_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f r5p_exec.f \
  --top-module r5p_exec_tb -o r5p_exec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/r5p_exec_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
